// File: common/pipe_pkg.sv
package pipe_pkg;

    // ========================================
    // alu operation select
    // ========================================
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_SLL  = 4'd2;
    localparam logic [3:0] ALU_SLT  = 4'd3;   // signed compare
    localparam logic [3:0] ALU_SLTU = 4'd4;   // unsigned compare
    localparam logic [3:0] ALU_XOR  = 4'd5;
    localparam logic [3:0] ALU_SRL  = 4'd6;
    localparam logic [3:0] ALU_SRA  = 4'd7;   // keeps the sign bit
    localparam logic [3:0] ALU_OR   = 4'd8;
    localparam logic [3:0] ALU_AND  = 4'd9;

    // ========================================
    // data memory access type
    // ========================================
    // same values as funct3 of the load opcode
    // bits [1:0] give the size, bit 2 marks unsigned
    // stores reuse LB/LH/LW for SB/SH/SW
    localparam logic [2:0] DMEM_LB  = 3'b000;
    localparam logic [2:0] DMEM_LH  = 3'b001;
    localparam logic [2:0] DMEM_LW  = 3'b010;
    localparam logic [2:0] DMEM_LBU = 3'b100;
    localparam logic [2:0] DMEM_LHU = 3'b101;

    // ========================================
    // writeback result source, one-hot
    // ========================================
    localparam logic [3:0] RES_ALU = 4'b0001;  // alu result
    localparam logic [3:0] RES_MEM = 4'b0010;  // load data
    localparam logic [3:0] RES_PC4 = 4'b0100;  // jal / jalr link
    localparam logic [3:0] RES_IMM = 4'b1000;  // lui

    // bit positions of the one-hot select
    localparam int RES_ALU_BIT = 0;
    localparam int RES_MEM_BIT = 1;
    localparam int RES_PC4_BIT = 2;
    localparam int RES_IMM_BIT = 3;

    // ========================================
    // data ram geometry
    // ========================================
    localparam int DMEM_WORDS = 256;                 // 1 KiB of data
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // word address bits

    // size field of a memory access
    localparam logic [1:0] SIZE_B = 2'b00;
    localparam logic [1:0] SIZE_H = 2'b01;
    localparam logic [1:0] SIZE_W = 2'b10;

endpackage

// File: design/exe_stage.sv
module exe_stage import pipe_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    // decoded instruction from the front end
    input  logic [4:0]  rs1_idx_i,
    input  logic [4:0]  rs2_idx_i,
    input  logic [31:0] rs1_data_i,       // register file read data, may be stale
    input  logic [31:0] rs2_data_i,
    input  logic [31:0] imm_i,
    input  logic [31:0] pc_i,
    input  logic [3:0]  alu_op_i,
    input  logic        alu_src_a_pc_i,   // auipc style operand a
    input  logic        alu_src_b_imm_i,  // immediate as operand b
    input  logic [2:0]  dmem_type_i,
    input  logic        dmem_we_i,
    input  logic        reg_write_en_i,
    input  logic [4:0]  rd_idx_i,
    input  logic [3:0]  result_src_i,

    // forwarding sources
    input  logic [31:0] bypass_m_i,       // instruction one ahead
    input  logic [4:0]  rd_idx_m_i,
    input  logic        reg_write_en_m_i,
    input  logic [31:0] wb_data_i,        // instruction two ahead
    input  logic [4:0]  wb_idx_i,
    input  logic        wb_en_i,

    // EXE/MEM register
    output logic [31:0] alu_result_e_o,
    output logic [31:0] store_data_e_o,
    output logic [2:0]  dmem_type_e_o,
    output logic        dmem_we_e_o,
    output logic [31:0] imm_e_o,
    output logic [31:0] pc_plus4_e_o,
    output logic        reg_write_en_e_o,
    output logic [4:0]  rd_idx_e_o,
    output logic [3:0]  result_src_e_o
);

    logic [31:0] rs1_fwd;
    logic [31:0] rs2_fwd;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [4:0]  shamt;

    // newest producer wins, x0 is never forwarded
    function automatic logic [31:0] fwd_sel(input logic [4:0] idx, input logic [31:0] rf_data);
        logic [31:0] res;
        res = rf_data;
        if (idx != 5'd0 && wb_en_i && wb_idx_i == idx)
            res = wb_data_i;
        if (idx != 5'd0 && reg_write_en_m_i && rd_idx_m_i == idx)
            res = bypass_m_i;                       // overrides the older wb value
        return res;
    endfunction

    always_comb begin
        rs1_fwd = fwd_sel(rs1_idx_i, rs1_data_i);
        rs2_fwd = fwd_sel(rs2_idx_i, rs2_data_i);
    end

    assign op_a  = alu_src_a_pc_i  ? pc_i  : rs1_fwd;
    assign op_b  = alu_src_b_imm_i ? imm_i : rs2_fwd;
    assign shamt = op_b[4:0];

    // ========================================
    // alu
    // ========================================
    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'd0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;        // unused codes act as add
        endcase
    end

    // ========================================
    // EXE/MEM register
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_write_en_e_o <= 1'b0;
            dmem_we_e_o      <= 1'b0;
        end else begin
            reg_write_en_e_o <= reg_write_en_i;
            dmem_we_e_o      <= dmem_we_i;
        end
    end

    // payload follows every cycle
    always_ff @(posedge clk) begin
        alu_result_e_o <= alu_res;
        store_data_e_o <= rs2_fwd;                  // forwarded store data
        dmem_type_e_o  <= dmem_type_i;
        imm_e_o        <= imm_i;
        pc_plus4_e_o   <= pc_i + 32'd4;
        rd_idx_e_o     <= rd_idx_i;
        result_src_e_o <= result_src_i;
    end

endmodule

// File: mem_stage/mem_stage.sv
module mem_stage import pipe_pkg::*; (
    input  logic               clk,
    input  logic               resetn,

    // EXE/MEM register
    input  logic [31:0]        alu_result_e_i,   // also the memory address
    input  logic [31:0]        store_data_e_i,
    input  logic [2:0]         dmem_type_e_i,
    input  logic               dmem_we_e_i,
    input  logic [31:0]        imm_e_i,
    input  logic [31:0]        pc_plus4_e_i,
    input  logic               reg_write_en_e_i,
    input  logic [4:0]         rd_idx_e_i,
    input  logic [3:0]         result_src_e_i,

    // data ram port
    output logic [DMEM_AW-1:0] ram_addr_o,
    output logic [3:0]         ram_be_o,
    output logic [31:0]        ram_wdata_o,
    output logic               ram_we_o,

    // MEM/WB register
    output logic [31:0]        alu_result_m_o,
    output logic [31:0]        imm_m_o,
    output logic [31:0]        pc_plus4_m_o,
    output logic               reg_write_en_m_o,
    output logic [4:0]         rd_idx_m_o,
    output logic [3:0]         result_src_m_o,
    output logic [2:0]         dmem_type_m_o,
    output logic [1:0]         byte_off_m_o,

    // forwarding value of the instruction in this stage
    output logic [31:0]        bypass_m_o
);

    logic [1:0] byte_off;
    logic [1:0] size;

    assign byte_off = alu_result_e_i[1:0];
    assign size     = dmem_type_e_i[1:0];          // sign bit does not matter here

    // ========================================
    // ram request
    // ========================================
    assign ram_addr_o = alu_result_e_i[DMEM_AW+1:2];  // word address
    assign ram_we_o   = dmem_we_e_i;

    // store data is copied into every lane it may land in
    always_comb begin
        case (size)
            SIZE_B:  ram_wdata_o = {4{store_data_e_i[7:0]}};
            SIZE_H:  ram_wdata_o = {2{store_data_e_i[15:0]}};
            default: ram_wdata_o = store_data_e_i;
        endcase
    end

    // byte lane mask from size and offset
    always_comb begin
        case (size)
            SIZE_B:  ram_be_o = 4'b0001 << byte_off;
            SIZE_H:  ram_be_o = 4'b0011 << {byte_off[1], 1'b0};  // halfword aligned
            SIZE_W:  ram_be_o = 4'b1111;
            default: ram_be_o = 4'b1111;
        endcase
    end

    // ========================================
    // bypass
    // ========================================
    // load data is not ready yet, a load gives its address here
    always_comb begin
        if (result_src_e_i[RES_PC4_BIT])
            bypass_m_o = pc_plus4_e_i;
        else if (result_src_e_i[RES_IMM_BIT])
            bypass_m_o = imm_e_i;
        else
            bypass_m_o = alu_result_e_i;
    end

    // ========================================
    // MEM/WB register
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn)
            reg_write_en_m_o <= 1'b0;
        else
            reg_write_en_m_o <= reg_write_en_e_i;
    end

    always_ff @(posedge clk) begin
        alu_result_m_o <= alu_result_e_i;
        imm_m_o        <= imm_e_i;
        pc_plus4_m_o   <= pc_plus4_e_i;
        rd_idx_m_o     <= rd_idx_e_i;
        result_src_m_o <= result_src_e_i;
        dmem_type_m_o  <= dmem_type_e_i;   // load extraction in wb
        byte_off_m_o   <= byte_off;        // lines up with ram_rdata
    end

endmodule

// File: mem_stage/data_ram.sv
module data_ram import pipe_pkg::*; (
    input  logic               clk,
    input  logic [DMEM_AW-1:0] addr_i,
    input  logic [3:0]         be_i,      // one enable per byte lane
    input  logic [31:0]        wdata_i,
    input  logic               we_i,
    output logic [31:0]        rdata_o    // valid the cycle after addr_i
);

    // ========================================
    // storage
    // ========================================
    logic [31:0] mem [DMEM_WORDS];

    // per-byte write
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (be_i[i])
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
    end

    // registered read
    // a write at the same edge is not seen, the old word comes out
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

// File: design/wb_stage.sv
module wb_stage import pipe_pkg::*; (
    // MEM/WB register
    input  logic [31:0] alu_result_m_i,
    input  logic [31:0] imm_m_i,
    input  logic [31:0] pc_plus4_m_i,
    input  logic        reg_write_en_m_i,
    input  logic [4:0]  rd_idx_m_i,
    input  logic [3:0]  result_src_m_i,    // one-hot
    input  logic [2:0]  dmem_type_m_i,
    input  logic [1:0]  byte_off_m_i,
    input  logic [31:0] ram_rdata_i,       // word read in the previous cycle

    // register file write port
    output logic        wb_en_o,
    output logic [4:0]  wb_idx_o,
    output logic [31:0] wb_data_o
);

    logic [31:0] shifted;
    logic [31:0] load_data;

    // ========================================
    // load extraction
    // ========================================
    assign shifted = ram_rdata_i >> {byte_off_m_i, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (dmem_type_m_i)
            DMEM_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            DMEM_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            DMEM_LBU: load_data = {24'd0, shifted[7:0]};
            DMEM_LHU: load_data = {16'd0, shifted[15:0]};
            default:  load_data = ram_rdata_i;   // lw
        endcase
    end

    // ========================================
    // result select
    // ========================================
    // and-or mux on the one-hot select
    assign wb_data_o = ({32{result_src_m_i[RES_ALU_BIT]}} & alu_result_m_i)
                     | ({32{result_src_m_i[RES_MEM_BIT]}} & load_data)
                     | ({32{result_src_m_i[RES_PC4_BIT]}} & pc_plus4_m_i)
                     | ({32{result_src_m_i[RES_IMM_BIT]}} & imm_m_i);

    assign wb_en_o  = reg_write_en_m_i;
    assign wb_idx_o = rd_idx_m_i;

endmodule

// File: design/backend_top.sv
module backend_top import pipe_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    input  logic [4:0]  rs1_idx_i,
    input  logic [4:0]  rs2_idx_i,
    input  logic [31:0] rs1_data_i,
    input  logic [31:0] rs2_data_i,
    input  logic [31:0] imm_i,
    input  logic [31:0] pc_i,
    input  logic [3:0]  alu_op_i,
    input  logic        alu_src_a_pc_i,
    input  logic        alu_src_b_imm_i,
    input  logic [2:0]  dmem_type_i,
    input  logic        dmem_we_i,
    input  logic        reg_write_en_i,
    input  logic [4:0]  rd_idx_i,
    input  logic [3:0]  result_src_i,

    output logic        wb_en_o,
    output logic [4:0]  wb_idx_o,
    output logic [31:0] wb_data_o,
    output logic [31:0] wb_pc_o         // pc+4 of the retiring instruction
);

    // ========================================
    // stage wires
    // ========================================
    logic [31:0] alu_result_e, store_data_e, imm_e, pc_plus4_e;
    logic [2:0]  dmem_type_e;
    logic        dmem_we_e, reg_write_en_e;
    logic [4:0]  rd_idx_e;
    logic [3:0]  result_src_e;

    logic [DMEM_AW-1:0] ram_addr;
    logic [3:0]         ram_be;
    logic [31:0]        ram_wdata, ram_rdata;
    logic               ram_we;

    logic [31:0] alu_result_m, imm_m, pc_plus4_m, bypass_m;
    logic        reg_write_en_m;
    logic [4:0]  rd_idx_m;
    logic [3:0]  result_src_m;
    logic [2:0]  dmem_type_m;
    logic [1:0]  byte_off_m;

    logic        wb_en;
    logic [4:0]  wb_idx;
    logic [31:0] wb_data;

    // the bypass belongs to the instruction held in EXE/MEM,
    // so its index and enable come from that register
    exe_stage i_exe_stage (
        .clk, .resetn,
        .rs1_idx_i, .rs2_idx_i, .rs1_data_i, .rs2_data_i, .imm_i, .pc_i,
        .alu_op_i, .alu_src_a_pc_i, .alu_src_b_imm_i, .dmem_type_i, .dmem_we_i,
        .reg_write_en_i, .rd_idx_i, .result_src_i,
        .bypass_m_i(bypass_m), .rd_idx_m_i(rd_idx_e), .reg_write_en_m_i(reg_write_en_e),
        .wb_data_i(wb_data), .wb_idx_i(wb_idx), .wb_en_i(wb_en),
        .alu_result_e_o(alu_result_e), .store_data_e_o(store_data_e),
        .dmem_type_e_o(dmem_type_e), .dmem_we_e_o(dmem_we_e), .imm_e_o(imm_e),
        .pc_plus4_e_o(pc_plus4_e), .reg_write_en_e_o(reg_write_en_e),
        .rd_idx_e_o(rd_idx_e), .result_src_e_o(result_src_e)
    );

    mem_stage i_mem_stage (
        .clk, .resetn,
        .alu_result_e_i(alu_result_e), .store_data_e_i(store_data_e),
        .dmem_type_e_i(dmem_type_e), .dmem_we_e_i(dmem_we_e), .imm_e_i(imm_e),
        .pc_plus4_e_i(pc_plus4_e), .reg_write_en_e_i(reg_write_en_e),
        .rd_idx_e_i(rd_idx_e), .result_src_e_i(result_src_e),
        .ram_addr_o(ram_addr), .ram_be_o(ram_be), .ram_wdata_o(ram_wdata), .ram_we_o(ram_we),
        .alu_result_m_o(alu_result_m), .imm_m_o(imm_m), .pc_plus4_m_o(pc_plus4_m),
        .reg_write_en_m_o(reg_write_en_m), .rd_idx_m_o(rd_idx_m),
        .result_src_m_o(result_src_m), .dmem_type_m_o(dmem_type_m),
        .byte_off_m_o(byte_off_m), .bypass_m_o(bypass_m)
    );

    data_ram i_data_ram (
        .clk,
        .addr_i(ram_addr), .be_i(ram_be), .wdata_i(ram_wdata), .we_i(ram_we),
        .rdata_o(ram_rdata)
    );

    wb_stage i_wb_stage (
        .alu_result_m_i(alu_result_m), .imm_m_i(imm_m), .pc_plus4_m_i(pc_plus4_m),
        .reg_write_en_m_i(reg_write_en_m), .rd_idx_m_i(rd_idx_m),
        .result_src_m_i(result_src_m), .dmem_type_m_i(dmem_type_m),
        .byte_off_m_i(byte_off_m), .ram_rdata_i(ram_rdata),
        .wb_en_o(wb_en), .wb_idx_o(wb_idx), .wb_data_o(wb_data)
    );

    assign wb_en_o   = wb_en;
    assign wb_idx_o  = wb_idx;
    assign wb_data_o = wb_data;
    assign wb_pc_o   = pc_plus4_m;

endmodule

// File: tb/backend_assert.sv
module backend_assert import pipe_pkg::*; (
    input logic        clk,
    input logic        resetn,
    input logic        wb_en_o,
    input logic [31:0] wb_data_o,
    input logic        ram_we,
    input logic [3:0]  ram_be,
    input logic [2:0]  dmem_type_e
);
    timeunit 1ns;
    timeprecision 1ps;

    // ========================================
    // pipeline properties
    // ========================================
    // nothing retires right after reset
    a_idle_after_reset: assert property (@(posedge clk) $rose(resetn) |-> !wb_en_o ##1 !wb_en_o)
        else $error("wb_en_o high right after reset release");

    a_wb_data_known: assert property (@(posedge clk) disable iff (!resetn)
        wb_en_o |-> !$isunknown(wb_data_o))
        else $error("wb_data_o has unknown bits during writeback");

    // a word store must write all four lanes
    a_word_store_be: assert property (@(posedge clk) disable iff (!resetn)
        (ram_we && dmem_type_e[1:0] == SIZE_W) |-> ram_be == 4'b1111)
        else $error("word store with a byte lane disabled");

endmodule

bind backend_top backend_assert i_backend_assert (
    .clk(clk), .resetn(resetn), .wb_en_o(wb_en_o), .wb_data_o(wb_data_o),
    .ram_we(ram_we), .ram_be(ram_be), .dmem_type_e(dmem_type_e)
);

// File: tb/backend_tb.sv
module backend_tb;
    import pipe_pkg::*;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        resetn;
    logic [4:0]  rs1_idx, rs2_idx, rd_idx;
    logic [31:0] rs1_data, rs2_data, imm, pc;
    logic [3:0]  alu_op, result_src;
    logic        alu_src_a_pc, alu_src_b_imm, dmem_we, reg_write_en;
    logic [2:0]  dmem_type;
    logic        wb_en;
    logic [4:0]  wb_idx;
    logic [31:0] wb_data, wb_pc;

    // golden model state
    logic [31:0] regs [32];
    logic [7:0]  mem_m [1024];     // byte view of the data ram
    logic [69:0] pend [$];         // {en, idx, data, pc4} per issued slot
    logic [31:0] pc_cnt;
    string       test_name;
    int          seed = 36;

    backend_top i_backend_top (
        .clk, .resetn,
        .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data), .imm_i(imm), .pc_i(pc), .alu_op_i(alu_op),
        .alu_src_a_pc_i(alu_src_a_pc), .alu_src_b_imm_i(alu_src_b_imm),
        .dmem_type_i(dmem_type), .dmem_we_i(dmem_we), .reg_write_en_i(reg_write_en),
        .rd_idx_i(rd_idx), .result_src_i(result_src),
        .wb_en_o(wb_en), .wb_idx_o(wb_idx), .wb_data_o(wb_data), .wb_pc_o(wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    // ========================================
    // reference model
    // ========================================
    function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] r;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_SLL:  r = a << b[4:0];
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> b[4:0];
            ALU_SRA: begin
                r = a >> b[4:0];
                if (a[31])
                    r = r | ~(32'hffff_ffff >> b[4:0]);   // fill with sign
            end
            ALU_OR:   r = a | b;
            default:  r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] t, input logic [31:0] addr);
        logic [9:0]  a;
        logic [15:0] h;
        a = addr[9:0];
        h = {mem_m[a + 10'd1], mem_m[a]};
        case (t)
            DMEM_LB:  return {{24{mem_m[a][7]}}, mem_m[a]};
            DMEM_LBU: return {24'd0, mem_m[a]};
            DMEM_LH:  return {{16{h[15]}}, h};
            DMEM_LHU: return {16'd0, h};
            default:  return {mem_m[a + 10'd3], mem_m[a + 10'd2], h};
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    // ========================================
    // issue one slot and check the one two slots back
    // ========================================
    task automatic issue(input logic [3:0] op, input logic [4:0] s1, input logic [4:0] s2,
                         input logic [4:0] rd, input logic [31:0] im, input logic a_pc,
                         input logic b_imm, input logic [2:0] t, input logic dwe,
                         input logic rwe, input logic [3:0] rsrc, input logic stale);
        logic [31:0] a, b, res, addr, sd;
        logic [69:0] e;
        a    = a_pc ? pc_cnt : regs[s1];
        b    = b_imm ? im : regs[s2];
        addr = alu_ref(op, a, b);
        sd   = regs[s2];
        case (rsrc)
            RES_MEM: res = load_ref(t, addr);
            RES_PC4: res = pc_cnt + 32'd4;
            RES_IMM: res = im;
            default: res = addr;
        endcase
        @(posedge clk);
        rs1_idx  <= s1;
        rs2_idx  <= s2;
        // stale register file data proves that forwarding took place
        rs1_data <= (stale && s1 != 0) ? regs[s1] ^ 32'h5a5a_a5a5 : regs[s1];
        rs2_data <= (stale && s2 != 0) ? regs[s2] ^ 32'h5a5a_a5a5 : regs[s2];
        rd_idx   <= rd;
        imm      <= im;
        pc       <= pc_cnt;
        alu_op   <= op;
        alu_src_a_pc  <= a_pc;
        alu_src_b_imm <= b_imm;
        dmem_type     <= t;
        dmem_we       <= dwe;
        reg_write_en  <= rwe;
        result_src    <= rsrc;
        if (dwe) begin                    // store updates the byte model
            mem_m[addr[9:0]] = sd[7:0];
            if (t[1:0] != SIZE_B)
                mem_m[addr[9:0] + 10'd1] = sd[15:8];
            if (t[1:0] == SIZE_W) begin
                mem_m[addr[9:0] + 10'd2] = sd[23:16];
                mem_m[addr[9:0] + 10'd3] = sd[31:24];
            end
        end
        pend.push_back({rwe, rd, res, pc_cnt + 32'd4});
        if (rwe && rd != 0)
            regs[rd] = res;
        pc_cnt = pc_cnt + 32'd4;
        @(negedge clk);                   // outputs settled
        if (pend.size() > 2) begin
            e = pend.pop_front();
            check("wb_en", {31'd0, e[69]}, {31'd0, wb_en});
            if (e[69]) begin
                check("wb_idx", {27'd0, e[68:64]}, {27'd0, wb_idx});
                check("wb_data", e[63:32], wb_data);
                check("wb_pc", e[31:0], wb_pc);
            end
        end
    endtask

    task automatic bubble();
        issue(ALU_ADD, 0, 0, 0, 0, 0, 0, DMEM_LW, 0, 0, RES_ALU, 0);
    endtask

    task automatic alu_rr(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] s1,
                          input logic [4:0] s2, input logic stale);
        issue(op, s1, s2, rd, 0, 0, 0, DMEM_LW, 0, 1, RES_ALU, stale);
    endtask

    task automatic alu_ri(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] s1,
                          input logic [31:0] im, input logic stale);
        issue(op, s1, 0, rd, im, 0, 1, DMEM_LW, 0, 1, RES_ALU, stale);
    endtask

    // base address in x5, store data in x6, load target x10
    task automatic store(input logic [2:0] t, input logic [31:0] off);
        issue(ALU_ADD, 5, 6, 0, off, 0, 1, t, 1, 0, RES_ALU, 0);
    endtask

    task automatic load(input logic [2:0] t, input logic [31:0] off);
        issue(ALU_ADD, 5, 0, 10, off, 0, 1, t, 0, 1, RES_MEM, 0);
    endtask

    // two bubbles push the last two real slots through writeback
    task automatic drain();
        bubble();
        bubble();
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        resetn       <= 1'b0;
        reg_write_en <= 1'b0;
        dmem_we      <= 1'b0;
        repeat (cycles - 1) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        pend.delete();
        pend.push_back(70'd0);            // nothing may retire in the first two slots
        pend.push_back(70'd0);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_alu();
        logic [3:0] ops [10];
        test_name = "test_alu";
        ops = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
                ALU_OR, ALU_AND};
        for (int i = 0; i < 10; i++) begin
            alu_ri(ALU_ADD, 1, 0, $random(seed), 0);
            alu_ri(ALU_ADD, 2, 0, $random(seed), 0);
            bubble();
            alu_rr(ops[i], 3, 1, 2, 0);   // register operands
            bubble();
            alu_ri(ops[i], 4, 1, $random(seed), 0);
            bubble();
        end
        drain();
    endtask

    task automatic test_forward();
        test_name = "test_forward";
        alu_ri(ALU_ADD, 7, 0, 32'h1234_5678, 0);
        alu_rr(ALU_ADD, 8, 7, 0, 1);      // distance 1, bypass
        alu_ri(ALU_ADD, 9, 0, 32'h0bad_f00d, 0);
        bubble();
        alu_rr(ALU_OR, 10, 9, 0, 1);      // distance 2, writeback value
        alu_ri(ALU_ADD, 11, 0, 32'h0000_1111, 0);
        alu_ri(ALU_ADD, 11, 0, 32'h0000_2222, 0);
        alu_rr(ALU_ADD, 12, 11, 11, 1);   // newer producer wins
        issue(ALU_ADD, 0, 0, 14, 32'hfeed_0000, 0, 0, DMEM_LW, 0, 1, RES_IMM, 0);
        alu_rr(ALU_XOR, 15, 14, 0, 1);    // lui result through bypass
        alu_ri(ALU_ADD, 0, 0, 32'hdead_beef, 0);
        alu_rr(ALU_ADD, 13, 0, 0, 1);     // x0 stays zero
        drain();
    endtask

    task automatic test_load_store();
        test_name = "test_load_store";
        for (int w = 0; w < 4; w++) begin
            alu_ri(ALU_ADD, 5, 0, $random(seed) & 32'h3fc, 0);
            alu_ri(ALU_ADD, 6, 0, $random(seed), 0);
            store(DMEM_LW, 0);
            load(DMEM_LW, 0);             // right behind the store
            for (int o = 0; o < 4; o++) begin
                alu_ri(ALU_ADD, 6, 0, $random(seed), 0);
                store(DMEM_LB, o);
                load(DMEM_LBU, o);
            end
            for (int o = 0; o < 4; o += 2) begin
                alu_ri(ALU_ADD, 6, 0, $random(seed), 0);
                store(DMEM_LH, o);
                load(DMEM_LH, o);
                load(DMEM_LHU, o);
            end
            for (int o = 0; o < 4; o++) begin
                load(DMEM_LB, o);
                load(DMEM_LBU, o);
            end
            load(DMEM_LW, 0);
        end
        drain();
    endtask

    task automatic test_result_src();
        test_name = "test_result_src";
        issue(ALU_ADD, 0, 0, 16, 32'h0000_0040, 0, 1, DMEM_LW, 0, 1, RES_PC4, 0);  // jal
        issue(ALU_ADD, 0, 0, 17, 32'habcd_e000, 0, 1, DMEM_LW, 0, 1, RES_IMM, 0);  // lui
        issue(ALU_ADD, 0, 0, 18, 32'h0001_2000, 1, 1, DMEM_LW, 0, 1, RES_ALU, 0);  // auipc
        drain();
    endtask

    task automatic test_reset();
        test_name = "test_reset";
        alu_ri(ALU_ADD, 20, 0, 32'h1111_1111, 0);
        alu_ri(ALU_ADD, 21, 0, 32'h2222_2222, 0);
        apply_reset(4);                   // both still in flight
        bubble();
        bubble();
        alu_ri(ALU_ADD, 22, 0, 32'h3333_3333, 0);
        load(DMEM_LW, 0);                 // x5 still points at a written word
        drain();
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        resetn        <= 1'b0;
        rs1_idx       <= '0;
        rs2_idx       <= '0;
        rs1_data      <= '0;
        rs2_data      <= '0;
        imm           <= '0;
        pc            <= '0;
        alu_op        <= ALU_ADD;
        alu_src_a_pc  <= 1'b0;
        alu_src_b_imm <= 1'b0;
        dmem_type     <= DMEM_LW;
        dmem_we       <= 1'b0;
        reg_write_en  <= 1'b0;
        rd_idx        <= '0;
        result_src    <= RES_ALU;
        pc_cnt = 32'h0000_1000;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        apply_reset(16);
        test_alu();
        test_forward();
        test_load_store();
        test_result_src();
        test_reset();
        $display("PASS: all tests");
        $finish;
    end

    // hard limit on the whole run
    initial begin
        for (int i = 0; i < 5000; i++)
            @(posedge clk);
        $display("simulation did not finish within 5000 cycles");
        $display("FAIL: see errors above");
        $fatal(1, "global timeout");
    end

endmodule

// File: flist.f
common/pipe_pkg.sv
design/exe_stage.sv
mem_stage/mem_stage.sv
mem_stage/data_ram.sv
design/wb_stage.sv
design/backend_top.sv
tb/backend_assert.sv
tb/backend_tb.sv

// File: run.sh
#!/bin/sh
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module backend_tb \
    -f flist.f -o sim_backend > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_backend > sim.log 2>&1
cat sim.log

grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
